// File: verilog/expu_settings.svh
// Numeric parameters of the exponential unit row.
// Include wherever a lane count, register count or fixed-point constant is needed.

`ifndef EXPU_SETTINGS_SVH
`define EXPU_SETTINGS_SVH

// Operands per vector.
`define EXPU_NUM_LANES 4

// Pipeline registers in every lane.
`define EXPU_NUM_REGS 2

// Fractional bits of the fixed-point operand.
`define EXPU_A_FRACTION 14

// log2(e) * 2^14, rounded.
`define EXPU_LOG2E_Q 23637

`endif

// File: verilog/expu_pkg.sv
// Shared types of the exponential unit row.
// Refer to them by scoped name, e.g. expu_pkg::expu_vec_t.

`default_nettype none

`include "expu_settings.svh"

package expu_pkg;

    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [6:0] mantissa;
    } bf16_fields_t;

    // Raw word on the buses, split into fields inside the arithmetic.
    typedef union packed {
        logic [15:0]  raw;
        bf16_fields_t fields;
    } bf16_t;

    typedef struct packed {
        bf16_t [`EXPU_NUM_LANES-1:0] lanes;
    } expu_vec_t;

    // Where a lane puts its registers relative to the arithmetic.
    typedef enum logic [1:0] {
        BEFORE,
        AFTER,
        AROUND
    } reg_pos_e;

endpackage

`default_nettype wire

// File: verilog/expu_schraudolph.sv
// Schraudolph exponential of a single bfloat16 operand.
// Combinational only; expu_row adds the pipeline registers around it.

`default_nettype none

`include "expu_settings.svh"

module expu_schraudolph (
    input  expu_pkg::bf16_t op_i,
    output expu_pkg::bf16_t res_o
);

    localparam int unsigned A_FRAC = `EXPU_A_FRACTION;
    localparam int unsigned MAG_W  = 8 + A_FRAC;    // 8 integer bits.
    localparam int unsigned V_W    = MAG_W + 1;
    localparam int unsigned Y_W    = V_W + 16;
    localparam int unsigned Y_FRAC = 2 * A_FRAC;
    localparam int unsigned N_W    = Y_W - Y_FRAC;

    localparam logic signed [15:0] LOG2E = 16'(`EXPU_LOG2E_Q);
    localparam logic signed [N_W:0] BIAS = 127;

    logic [7:0]            shift;
    logic [MAG_W-1:0]      mag;
    logic signed [V_W-1:0] v;
    logic signed [Y_W-1:0] y;
    logic signed [N_W-1:0] n;
    logic signed [N_W:0]   exp_biased;
    logic                  is_nan;

    assign is_nan = (op_i.fields.exponent == 8'hFF) && (op_i.fields.mantissa != '0);

    // An exponent of 134 puts the hidden bit on the top integer bit.
    assign shift = 8'd134 - op_i.fields.exponent;

    always_comb begin
        if (op_i.fields.exponent == '0) begin
            mag = '0;                                   // Zero and subnormals.
        end else if (op_i.fields.exponent >= 8'd135) begin
            mag = '1;                                   // Saturate, inf included.
        end else begin
            mag = {1'b1, op_i.fields.mantissa, {A_FRAC{1'b0}}} >> shift;
        end
    end

    assign v = op_i.fields.sign ? -$signed({1'b0, mag}) : $signed({1'b0, mag});

    // x * log2(e) in Q.28.
    assign y = v * LOG2E;

    assign n          = y[Y_W-1:Y_FRAC];                // Floor of y.
    assign exp_biased = n + BIAS;

    always_comb begin
        res_o.raw = 16'h0000;                           // Underflow flushes to zero.
        if (is_nan) begin
            res_o.raw = 16'h7FC0;
        end else if (exp_biased >= 255) begin
            res_o.raw = 16'h7F80;
        end else if (exp_biased > 0) begin
            res_o.fields.sign     = 1'b0;
            res_o.fields.exponent = exp_biased[7:0];
            res_o.fields.mantissa = y[Y_FRAC-1 -: 7];   // Truncated fraction.
        end
    end

endmodule

`default_nettype wire

// File: verilog/expu_row.sv
// One exponential lane: a chain of enable-gated registers and the Schraudolph block.
// REG_POS puts the chain before, after or around the arithmetic.

`default_nettype none

`include "expu_settings.svh"

module expu_row #(
    parameter int unsigned        NUM_REGS = `EXPU_NUM_REGS,
    parameter expu_pkg::reg_pos_e REG_POS  = expu_pkg::AROUND
) (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,
    input  wire logic                clear_i,
    input  wire logic [NUM_REGS-1:0] enable_i,
    input  expu_pkg::bf16_t          op_i,
    output expu_pkg::bf16_t          res_o
);

    expu_pkg::bf16_t chain [0:NUM_REGS];
    expu_pkg::bf16_t op_sch;
    expu_pkg::bf16_t res_sch;

    if (REG_POS == expu_pkg::BEFORE) begin : gen_before
        assign chain[0] = op_i;
        assign op_sch   = chain[NUM_REGS];
        assign res_o    = res_sch;
    end else if (REG_POS == expu_pkg::AFTER) begin : gen_after
        assign chain[0] = res_sch;
        assign op_sch   = op_i;
        assign res_o    = chain[NUM_REGS];
    end else begin : gen_around
        assign chain[0] = op_i;
        assign op_sch   = chain[NUM_REGS/2];
        assign res_o    = chain[NUM_REGS];
    end

    for (genvar i = 0; i < NUM_REGS; i++) begin : gen_regs
        expu_pkg::bf16_t d;

        // Middle register of the split chain takes the arithmetic result.
        if (REG_POS == expu_pkg::AROUND && i == NUM_REGS / 2) begin : gen_mid
            assign d = res_sch;
        end else begin : gen_pass
            assign d = chain[i];
        end

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                chain[i+1] <= '0;
            end else if (clear_i) begin
                chain[i+1] <= '0;
            end else if (enable_i[i]) begin
                chain[i+1] <= d;
            end
        end
    end

    expu_schraudolph u_schraudolph (
        .op_i  (op_sch),
        .res_o (res_sch)
    );

endmodule

`default_nettype wire

// File: verilog/expu_core.sv
// Processing part of the row: one valid bit per pipeline stage and all lanes.
// Stages fill up behind a blocked output, so bubbles collapse.
// Takes and gives vectors over one-cycle valid/ready pairs.

`default_nettype none

`include "expu_settings.svh"

module expu_core #(
    parameter expu_pkg::reg_pos_e REG_POS = expu_pkg::AROUND
) (
    input  wire logic          clk_i,
    input  wire logic          rst_ni,
    input  wire logic          clear_i,
    input  expu_pkg::expu_vec_t in_vec_i,
    input  wire logic          in_valid_i,
    output logic               in_ready_o,
    output expu_pkg::expu_vec_t res_vec_o,
    output logic               res_valid_o,
    input  wire logic          res_ready_i
);

    localparam int unsigned NUM_REGS  = `EXPU_NUM_REGS;
    localparam int unsigned NUM_LANES = `EXPU_NUM_LANES;

    logic [NUM_REGS-1:0] valid_q;
    logic [NUM_REGS:0]   valid_chain;
    logic [NUM_REGS-1:0] stage_ready;
    logic [NUM_REGS-1:0] enable;

    assign valid_chain = {valid_q, in_valid_i};

    // A stage may load when it is empty or its content moves on.
    always_comb begin
        logic downstream;
        downstream = res_ready_i;
        for (int i = NUM_REGS - 1; i >= 0; i--) begin
            stage_ready[i] = !valid_q[i] || downstream;
            downstream     = stage_ready[i];
        end
    end

    assign enable = stage_ready & valid_chain[NUM_REGS-1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (clear_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q & ~stage_ready) | (valid_chain[NUM_REGS-1:0] & stage_ready);
        end
    end

    assign in_ready_o  = stage_ready[0];
    assign res_valid_o = valid_q[NUM_REGS-1];

    for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lanes
        expu_row #(
            .NUM_REGS (NUM_REGS),
            .REG_POS  (REG_POS)
        ) u_row (
            .clk_i    (clk_i),
            .rst_ni   (rst_ni),
            .clear_i  (clear_i),
            .enable_i (enable),            // Shared by all lanes.
            .op_i     (in_vec_i.lanes[l]),
            .res_o    (res_vec_o.lanes[l])
        );
    end

endmodule

`default_nettype wire

// File: verilog/expu_in_port.sv
// Four-phase req/ack receiver on the input side.
// Captures one vector, offers it to the core, then acks until req falls.

`default_nettype none

module expu_in_port (
    input  wire logic           clk_i,
    input  wire logic           rst_ni,
    input  wire logic           clear_i,
    input  wire logic           req_i,
    input  expu_pkg::expu_vec_t data_i,
    output logic                ack_o,
    output expu_pkg::expu_vec_t vec_o,
    output logic                valid_o,
    input  wire logic           ready_i
);

    localparam logic [1:0] IDLE     = 2'd0;
    localparam logic [1:0] OFFER    = 2'd1;
    localparam logic [1:0] ACK_WAIT = 2'd2;

    logic [1:0]          state_q;
    expu_pkg::expu_vec_t vec_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:     if (req_i) state_q <= OFFER;
                // A clear drops the vector but the handshake still completes.
                OFFER:    if (ready_i || clear_i) state_q <= ACK_WAIT;
                ACK_WAIT: if (!req_i) state_q <= IDLE;
                default:  state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && req_i) begin
            vec_q <= data_i;
        end
    end

    assign vec_o   = vec_q;
    assign valid_o = (state_q == OFFER);
    assign ack_o   = (state_q == ACK_WAIT);

endmodule

`default_nettype wire

// File: verilog/expu_out_port.sv
// Four-phase req/ack sender on the output side.
// Holds one result from the core and is ready again once ack has fallen.

`default_nettype none

module expu_out_port (
    input  wire logic           clk_i,
    input  wire logic           rst_ni,
    input  wire logic           clear_i,
    input  expu_pkg::expu_vec_t vec_i,
    input  wire logic           valid_i,
    output logic                ready_o,
    output logic                req_o,
    output expu_pkg::expu_vec_t data_o,
    input  wire logic           ack_i
);

    localparam logic [1:0] IDLE     = 2'd0;
    localparam logic [1:0] REQ      = 2'd1;
    localparam logic [1:0] ACK_HIGH = 2'd2;

    logic [1:0]          state_q;
    expu_pkg::expu_vec_t data_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:     if (valid_i && !clear_i) state_q <= REQ;
                REQ: begin
                    if (clear_i) begin
                        state_q <= IDLE;    // Result withdrawn.
                    end else if (ack_i) begin
                        state_q <= ACK_HIGH;
                    end
                end
                ACK_HIGH: if (!ack_i) state_q <= IDLE;
                default:  state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && valid_i) begin
            data_q <= vec_i;
        end
    end

    assign ready_o = (state_q == IDLE);
    assign req_o   = (state_q == REQ);
    assign data_o  = data_q;

endmodule

`default_nettype wire

// File: verilog/expu_top.sv
// Top level of the exponential unit row.
// Four-phase input port, pipelined core and four-phase output port in series.

`default_nettype none

module expu_top (
    input  wire logic           clk_i,
    input  wire logic           rst_ni,
    input  wire logic           clear_i,
    input  wire logic           in_req_i,
    input  expu_pkg::expu_vec_t in_data_i,
    output logic                in_ack_o,
    output logic                out_req_o,
    output expu_pkg::expu_vec_t out_data_o,
    input  wire logic           out_ack_i
);

    expu_pkg::expu_vec_t in_vec;
    logic                in_valid;
    logic                in_ready;
    expu_pkg::expu_vec_t res_vec;
    logic                res_valid;
    logic                res_ready;

    expu_in_port u_in_port (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .req_i   (in_req_i),
        .data_i  (in_data_i),
        .ack_o   (in_ack_o),
        .vec_o   (in_vec),
        .valid_o (in_valid),
        .ready_i (in_ready)
    );

    expu_core u_core (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .in_vec_i    (in_vec),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .res_vec_o   (res_vec),
        .res_valid_o (res_valid),
        .res_ready_i (res_ready)
    );

    expu_out_port u_out_port (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .vec_i   (res_vec),
        .valid_i (res_valid),
        .ready_o (res_ready),
        .req_o   (out_req_o),
        .data_o  (out_data_o),
        .ack_i   (out_ack_i)
    );

endmodule

`default_nettype wire

// File: verification/expu_chk.sv
// Handshake assertions on both four-phase ports of the exponential unit row.
// Bound onto expu_top, so every instance of the top level is checked.

`default_nettype none

module expu_chk (
    input wire logic                clk_i,
    input wire logic                rst_ni,
    input wire logic                clear_i,
    input wire logic                in_req_i,
    input wire expu_pkg::expu_vec_t in_data_i,
    input wire logic                in_ack_o,
    input wire logic                out_req_o,
    input wire expu_pkg::expu_vec_t out_data_o,
    input wire logic                out_ack_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Req and data hold until ack.
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_req_i && !in_ack_o |=> in_ack_o || (in_req_i && $stable(in_data_i)))
        else $error("in_req_i or in_data_i changed before in_ack_o");

    // A clear may withdraw a pending result.
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_req_o && !out_ack_i && !clear_i |=> out_ack_i || (out_req_o && $stable(out_data_o)))
        else $error("out_req_o or out_data_o changed before out_ack_i");

    assert property (@(posedge clk_i) disable iff (!rst_ni) $rose(in_ack_o) |-> $past(in_req_i))
        else $error("in_ack_o rose without in_req_i");

    assert property (@(posedge clk_i) disable iff (!rst_ni) $rose(out_ack_i) |-> out_req_o)
        else $error("out_ack_i rose without out_req_o");

    assert property (@(posedge clk_i) !rst_ni |-> !out_req_o)
        else $error("out_req_o high during reset");

endmodule

bind expu_top expu_chk u_chk (.*);

`default_nettype wire

// File: verification/expu_tb.sv
// Testbench for the exponential unit row.
// Sends bfloat16 vectors over the four-phase input port and checks every result against a model.

`default_nettype none

`include "expu_settings.svh"

module expu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 1000;
    localparam int Q       = 2 * `EXPU_A_FRACTION;   // Fraction bits of the product.

    logic                clk_i;
    logic                rst_ni;
    logic                clear_i;
    logic                in_req_i;
    logic                in_ack_o;
    logic                out_req_o;
    logic                out_ack_i;
    expu_pkg::expu_vec_t in_data_i;
    expu_pkg::expu_vec_t out_data_o;

    expu_pkg::expu_vec_t scoreboard[$];
    int   n_checks  = 0;
    int   n_errors  = 0;
    int   n_other   = 0;
    logic ack_hold  = 1'b0;
    logic bp_mode   = 1'b0;
    logic resp_busy = 1'b0;

    expu_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // x * log2(e) in fixed point; floor gives the exponent, the fraction gives the mantissa.
    function automatic expu_pkg::bf16_t ref_exp(input expu_pkg::bf16_t op);
        expu_pkg::bf16_t res;
        longint          v;
        longint          y;
        longint          n;
        int              sh;
        sh = int'(op.fields.exponent) - 127 - 7 + `EXPU_A_FRACTION;
        if (op.fields.exponent == 8'd0) v = 0;
        else if (op.fields.exponent >= 8'd135) v = (longint'(1) << (8 + `EXPU_A_FRACTION)) - 1;
        else if (sh >= 0) v = longint'({1'b1, op.fields.mantissa}) << sh;
        else v = longint'({1'b1, op.fields.mantissa}) >> (-sh);
        if (op.fields.sign) v = -v;
        y = v * `EXPU_LOG2E_Q;
        n = (y >>> Q) + 127;
        res.raw = 16'h0000;
        if (op.fields.exponent == 8'hFF && op.fields.mantissa != 7'd0) res.raw = 16'h7FC0;
        else if (n >= 255) res.raw = 16'h7F80;
        else if (n > 0) begin
            res.fields.exponent = 8'(n);
            res.fields.mantissa = 7'(y >> (Q - 7));  // Truncated.
        end
        return res;
    endfunction

    function automatic expu_pkg::expu_vec_t ref_vec(input expu_pkg::expu_vec_t vec);
        expu_pkg::expu_vec_t res;
        for (int l = 0; l < `EXPU_NUM_LANES; l++) begin
            res.lanes[l] = ref_exp(vec.lanes[l]);
        end
        return res;
    endfunction

    task automatic check_vec(input string name, input expu_pkg::expu_vec_t got,
                             input expu_pkg::expu_vec_t want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("FAIL %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("FAIL %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic step_or_timeout(inout int cycles, input string what);
        @(negedge clk_i);
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timed out waiting for %s", what);
            $display("Checks %0d, wrong values %0d, other errors %0d", n_checks, n_errors, n_other);
            $display("** FAIL **");
            $finish;
        end
    endtask

    task automatic send_vec(input expu_pkg::expu_vec_t vec);
        int cycles;
        in_data_i = vec;
        in_req_i  = 1'b1;
        cycles    = 0;
        while (in_ack_o !== 1'b1) step_or_timeout(cycles, "in_ack_o to rise");
        scoreboard.push_back(ref_vec(vec));
        in_req_i = 1'b0;
        cycles   = 0;
        while (in_ack_o !== 1'b0) step_or_timeout(cycles, "in_ack_o to fall");
    endtask

    task automatic send_random(input int count);
        expu_pkg::expu_vec_t vec;
        for (int i = 0; i < count; i++) begin
            for (int l = 0; l < `EXPU_NUM_LANES; l++) begin
                vec.lanes[l].raw = 16'($urandom);
                // Mostly exponents near the bias for finite results.
                if ($urandom % 8 != 0) vec.lanes[l].fields.exponent = 8'(112 + $urandom % 28);
            end
            send_vec(vec);
        end
    endtask

    task automatic drain_results();
        int cycles;
        cycles = 0;
        while (scoreboard.size() != 0 || resp_busy) step_or_timeout(cycles, "outstanding results");
    endtask

    // Output responder and compare process.
    initial begin : responder
        int cycles;
        int delay;
        out_ack_i = 1'b0;
        forever begin
            @(negedge clk_i);
            if (out_req_o && !ack_hold) begin
                resp_busy = 1'b1;
                delay = bp_mode ? int'($urandom % 8) : 0;
                repeat (delay) @(negedge clk_i);
                check_flag("out_req_o", out_req_o, 1'b1);
                if (scoreboard.size() == 0) begin
                    n_other++;
                    $display("Result %h arrived with no vector outstanding", out_data_o);
                end else begin
                    check_vec("out_data_o", out_data_o, scoreboard.pop_front());
                end
                out_ack_i = 1'b1;
                cycles    = 0;
                while (out_req_o !== 1'b0) step_or_timeout(cycles, "out_req_o to fall");
                out_ack_i = 1'b0;
                resp_busy = 1'b0;
            end
        end
    end

    initial begin
        void'($urandom(27));
        rst_ni    = 1'b0;
        clear_i   = 1'b0;
        in_req_i  = 1'b0;
        in_data_i = '0;
        repeat (3) @(negedge clk_i);
        check_flag("out_req_o", out_req_o, 1'b0);
        check_flag("in_ack_o", in_ack_o, 1'b0);
        rst_ni = 1'b1;
        send_vec(64'h4000_BF80_3F80_0000);      // Lane 0 low. 0, 1, -1, 2.
        send_vec(64'h3F80_0000_BF31_3F31);      // ln2, -ln2, 0, 1.
        send_vec(64'h7F80_7FC1_C300_4300);      // 128, -128, NaN, +inf.
        drain_results();
        send_random(200);
        drain_results();
        bp_mode = 1'b1;
        send_random(100);
        drain_results();
        // Fill the pipeline behind a blocked output, then flush it.
        bp_mode  = 1'b0;
        ack_hold = 1'b1;
        send_random(3);
        repeat (4) @(negedge clk_i);
        check_flag("out_req_o", out_req_o, 1'b1);
        clear_i = 1'b1;
        @(negedge clk_i);
        clear_i = 1'b0;
        scoreboard.delete();
        repeat (10) begin
            @(negedge clk_i);
            check_flag("out_req_o", out_req_o, 1'b0);
        end
        ack_hold = 1'b0;
        send_random(8);
        drain_results();
        $display("Checks %0d, wrong values %0d, other errors %0d", n_checks, n_errors, n_other);
        if (n_errors == 0 && n_other == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: expu_top.f
+incdir+verilog
verilog/expu_pkg.sv
verilog/expu_schraudolph.sv
verilog/expu_row.sv
verilog/expu_core.sv
verilog/expu_in_port.sv
verilog/expu_out_port.sv
verilog/expu_top.sv
verification/expu_chk.sv
verification/expu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the exponential unit row testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module expu_tb \
        -f expu_top.f --Mdir obj_dir -o expu_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/expu_sim); then
    printf '%s\n' "$output"
    echo "Simulation exited with an error"
    exit 1
fi
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qxF '** PASS **'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
